// File: logic/spu_shift_pkg.sv
package spu_shift_pkg;

	// register file geometry
	localparam int reg_addr_w = 7;
	localparam int data_w = 128;
	localparam int reg_count = 128;

	// stages between issue and register write
	localparam int wb_depth = 4;

	// instruction fields
	localparam int op_w = 11;
	localparam int imm_w = 7;

	// lane geometry of the shift unit
	localparam int half_w = 16;
	localparam int word_w = 32;
	localparam int half_lanes = data_w / half_w;
	localparam int word_lanes = data_w / word_w;
	// masking never keeps more than six count bits
	localparam int cnt_w = 6;

	// register forms
	localparam logic [0:op_w-1] op_shlh = 11'b00001011111;
	localparam logic [0:op_w-1] op_shl = 11'b00001011011;
	localparam logic [0:op_w-1] op_roth = 11'b00001011100;
	localparam logic [0:op_w-1] op_rot = 11'b00001011000;
	localparam logic [0:op_w-1] op_rothm = 11'b00001011101;
	localparam logic [0:op_w-1] op_rotm = 11'b00001011001;
	localparam logic [0:op_w-1] op_rotmah = 11'b00001011110;
	localparam logic [0:op_w-1] op_rotma = 11'b00001011010;
	// immediate forms
	localparam logic [0:op_w-1] op_shli = 11'b00001111011;
	localparam logic [0:op_w-1] op_rothi = 11'b00001111100;
	localparam logic [0:op_w-1] op_roti = 11'b00001111000;
	localparam logic [0:op_w-1] op_rotmahi = 11'b00001111110;
	localparam logic [0:op_w-1] op_rotmai = 11'b00001111010;
	localparam logic [0:op_w-1] op_nop = 11'b00000000001;

	// issue controller states
	localparam int state_w = 2;
	localparam logic [state_w-1:0] st_reset_hold = 2'd0;
	localparam logic [state_w-1:0] st_issue = 2'd1;
	localparam logic [state_w-1:0] st_hazard_wait = 2'd2;

	// operation class shared by all lanes
	typedef enum logic [1:0] {
		shift_left,
		rotate,
		rotate_mask,
		rotate_mask_alg
	} shift_kind_t;

	// one 32-bit word, bit 0 is the msb
	// rb and imm7 occupy the same field
	typedef union packed {
		struct packed {
			logic [0:op_w-1] op;
			logic [0:reg_addr_w-1] rb;
			logic [0:reg_addr_w-1] ra;
			logic [0:reg_addr_w-1] rt;
		} rr;
		struct packed {
			logic [0:op_w-1] op;
			logic [0:imm_w-1] imm7;
			logic [0:reg_addr_w-1] ra;
			logic [0:reg_addr_w-1] rt;
		} ri7;
	} instr_t;

endpackage

// File: logic/spu_regfile.sv
`timescale 1ns/100ps

module spu_regfile (
	input logic clk,
	input logic reset,
	input logic [0:spu_shift_pkg::reg_addr_w-1] ra_addr,
	input logic [0:spu_shift_pkg::reg_addr_w-1] rb_addr,
	output logic [0:spu_shift_pkg::data_w-1] ra_data,
	output logic [0:spu_shift_pkg::data_w-1] rb_data,
	input logic wb_we,
	input logic [0:spu_shift_pkg::reg_addr_w-1] wb_addr,
	input logic [0:spu_shift_pkg::data_w-1] wb_data,
	input logic ext_we,
	input logic [0:spu_shift_pkg::reg_addr_w-1] ext_addr,
	input logic [0:spu_shift_pkg::data_w-1] ext_data
);

	logic [0:spu_shift_pkg::data_w-1] regs [spu_shift_pkg::reg_count];

	// both source ports read without a clock
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];

	// single write per edge
	// write-back from the pipe beats the external port
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < spu_shift_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_we) begin
			regs[wb_addr] <= wb_data;
		end else if (ext_we) begin
			regs[ext_addr] <= ext_data;
		end
	end

	// external fill must not race a pipe write to the same register,
	// the external value would be dropped
	property p_no_write_collision;
		@(posedge clk) disable iff (reset)
		(wb_we && ext_we) |-> (wb_addr != ext_addr);
	endproperty
	a_no_write_collision: assert property (p_no_write_collision)
		else $error("write-back and external write both hit r%0d", wb_addr);

endmodule

// File: logic/spu_issue_ctrl.sv
`timescale 1ns/100ps

module spu_issue_ctrl (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input spu_shift_pkg::instr_t in_instr,
	input logic in_squash,
	output logic in_ready,
	input logic hazard,
	output logic [0:spu_shift_pkg::reg_addr_w-1] ra_addr,
	output logic [0:spu_shift_pkg::reg_addr_w-1] rb_addr,
	output logic issue_we,
	output logic [0:spu_shift_pkg::reg_addr_w-1] issue_rt,
	output spu_shift_pkg::shift_kind_t kind,
	output logic word_mode,
	output logic use_imm,
	output logic [0:spu_shift_pkg::imm_w-1] imm7,
	output logic uses_rb
);

	logic [spu_shift_pkg::state_w-1:0] state;
	logic [spu_shift_pkg::state_w-1:0] state_next;
	spu_shift_pkg::instr_t held_instr;
	logic held_valid;
	spu_shift_pkg::instr_t cur;
	logic writes;
	logic accept;
	logic go;

	// an empty holding register shows the incoming word
	// so the hazard check already covers the next candidate
	assign cur = held_valid ? held_instr : in_instr;

	// both views of the same word
	assign ra_addr = cur.rr.ra;
	assign rb_addr = cur.rr.rb;
	assign issue_rt = cur.rr.rt;
	assign imm7 = cur.ri7.imm7;

	always_comb begin
		uses_rb = 1'b0;
		use_imm = 1'b0;
		writes = 1'b0;
		case (cur.rr.op)
			spu_shift_pkg::op_shlh, spu_shift_pkg::op_shl,
			spu_shift_pkg::op_roth, spu_shift_pkg::op_rot,
			spu_shift_pkg::op_rothm, spu_shift_pkg::op_rotm,
			spu_shift_pkg::op_rotmah, spu_shift_pkg::op_rotma: begin
				uses_rb = 1'b1;
				writes = 1'b1;
			end
			spu_shift_pkg::op_shli, spu_shift_pkg::op_rothi, spu_shift_pkg::op_roti,
			spu_shift_pkg::op_rotmahi, spu_shift_pkg::op_rotmai: begin
				use_imm = 1'b1;
				writes = 1'b1;
			end
			// nop and anything unknown pass through as bubbles
			default: begin
				writes = 1'b0;
			end
		endcase
	end

	// operation class and element width
	always_comb begin
		case (cur.rr.op)
			spu_shift_pkg::op_roth, spu_shift_pkg::op_rot,
			spu_shift_pkg::op_rothi, spu_shift_pkg::op_roti: kind = spu_shift_pkg::rotate;
			spu_shift_pkg::op_rothm, spu_shift_pkg::op_rotm: kind = spu_shift_pkg::rotate_mask;
			spu_shift_pkg::op_rotmah, spu_shift_pkg::op_rotma,
			spu_shift_pkg::op_rotmahi, spu_shift_pkg::op_rotmai: begin
				kind = spu_shift_pkg::rotate_mask_alg;
			end
			default: kind = spu_shift_pkg::shift_left;
		endcase
		word_mode = cur.rr.op inside {spu_shift_pkg::op_shl, spu_shift_pkg::op_rot,
			spu_shift_pkg::op_rotm, spu_shift_pkg::op_rotma, spu_shift_pkg::op_shli,
			spu_shift_pkg::op_roti, spu_shift_pkg::op_rotmai};
	end

	// held word leaves once its sources are settled in the file
	assign go = held_valid && !hazard;
	assign issue_we = go && writes;
	assign in_ready = (state != spu_shift_pkg::st_reset_hold) && !hazard;
	assign accept = in_valid && in_ready;

	always_comb begin
		state_next = state;
		case (state)
			spu_shift_pkg::st_reset_hold: state_next = spu_shift_pkg::st_issue;
			spu_shift_pkg::st_issue: begin
				if (held_valid && hazard) begin
					state_next = spu_shift_pkg::st_hazard_wait;
				end
			end
			spu_shift_pkg::st_hazard_wait: begin
				if (!hazard) begin
					state_next = spu_shift_pkg::st_issue;
				end
			end
			default: state_next = spu_shift_pkg::st_reset_hold;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= spu_shift_pkg::st_reset_hold;
			held_valid <= 1'b0;
		end else begin
			state <= state_next;
			// squash from a taken branch leaves a bubble
			if (accept) begin
				held_valid <= !in_squash;
			end else if (go) begin
				held_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			held_instr <= in_instr;
		end
	end

	// the wait state always parks a word in the slot and never swaps it
	property p_wait_keeps_word;
		@(posedge clk) disable iff (reset)
		state == spu_shift_pkg::st_hazard_wait |-> held_valid && $stable(held_instr);
	endproperty
	a_wait_keeps_word: assert property (p_wait_keeps_word)
		else $error("hazard wait without a stable held word");

endmodule

// File: logic/spu_shift_rotate.sv
`timescale 1ns/100ps

module spu_shift_rotate (
	input logic [0:spu_shift_pkg::data_w-1] ra_data,
	input logic [0:spu_shift_pkg::data_w-1] rb_data,
	input logic [0:spu_shift_pkg::imm_w-1] imm7,
	input logic use_imm,
	input spu_shift_pkg::shift_kind_t kind,
	input logic word_mode,
	output logic [0:spu_shift_pkg::data_w-1] result
);

	logic [0:spu_shift_pkg::data_w-1] half_result;
	logic [0:spu_shift_pkg::data_w-1] word_result;

	// one lane, element right-aligned in x
	// word = 0 treats only x[15:0] as the element
	function automatic logic [31:0] lane_op(
		input logic [31:0] x,
		input logic [spu_shift_pkg::cnt_w-1:0] cnt,
		input spu_shift_pkg::shift_kind_t op_kind,
		input logic word
	);
		logic [6:0] w;
		logic [31:0] mask;
		logic [5:0] c_shl;
		logic [5:0] c_neg_raw;
		logic [5:0] c_neg;
		logic [4:0] c_rot;
		logic sign;
		logic [63:0] dbl;
		logic [63:0] sext;
		logic [63:0] ash;
		logic [31:0] r;

		w = word ? 7'd32 : 7'd16;
		mask = word ? 32'hffff_ffff : 32'h0000_ffff;

		// shift count, 5 bits for halfwords and 6 for words
		c_shl = word ? cnt : {1'b0, cnt[4:0]};
		// rotate-mask counts are negated before masking
		c_neg_raw = 6'd0 - cnt;
		c_neg = word ? c_neg_raw : {1'b0, c_neg_raw[4:0]};
		// rotate count wraps at the element width
		c_rot = word ? cnt[4:0] : {1'b0, cnt[3:0]};

		sign = word ? x[31] : x[15];

		// two copies side by side, the top element after a left shift is the rotation
		dbl = word ? {x, x} : {x[15:0], x[15:0], 32'h0};
		dbl = dbl << c_rot;

		// sign-extended to 64 bits so a count up to 63 fills with sign bits
		sext = word ? {{32{sign}}, x} : {{48{sign}}, x[15:0]};
		ash = $signed(sext) >>> c_neg;

		case (op_kind)
			spu_shift_pkg::shift_left: begin
				r = ({1'b0, c_shl} < w) ? ((x << c_shl) & mask) : '0;
			end
			spu_shift_pkg::rotate: begin
				r = word ? dbl[63:32] : {16'h0, dbl[63:48]};
			end
			spu_shift_pkg::rotate_mask: begin
				// logical right, past the width nothing is left
				r = ({1'b0, c_neg} < w) ? ((x & mask) >> c_neg) : '0;
			end
			default: begin
				// algebraic right
				r = ash[31:0] & mask;
			end
		endcase
		return r;
	endfunction

	// eight halfword lanes, lane 0 sits at bit 0
	for (genvar h = 0; h < spu_shift_pkg::half_lanes; h++) begin : g_half
		logic [spu_shift_pkg::cnt_w-1:0] cnt;
		logic [spu_shift_pkg::half_w-1:0] res;

		// low six bits of the rb lane, or of imm7 (sign extension only touches upper bits)
		assign cnt = use_imm ? imm7[1:spu_shift_pkg::imm_w-1]
			: rb_data[h*spu_shift_pkg::half_w+10 +: spu_shift_pkg::cnt_w];
		assign res = 16'(lane_op({16'h0, ra_data[h*spu_shift_pkg::half_w +: spu_shift_pkg::half_w]},
			cnt, kind, 1'b0));
		assign half_result[h*spu_shift_pkg::half_w +: spu_shift_pkg::half_w] = res;
	end

	// four word lanes
	for (genvar j = 0; j < spu_shift_pkg::word_lanes; j++) begin : g_word
		logic [spu_shift_pkg::cnt_w-1:0] cnt;
		logic [spu_shift_pkg::word_w-1:0] res;

		assign cnt = use_imm ? imm7[1:spu_shift_pkg::imm_w-1]
			: rb_data[j*spu_shift_pkg::word_w+26 +: spu_shift_pkg::cnt_w];
		assign res = lane_op(ra_data[j*spu_shift_pkg::word_w +: spu_shift_pkg::word_w],
			cnt, kind, 1'b1);
		assign word_result[j*spu_shift_pkg::word_w +: spu_shift_pkg::word_w] = res;
	end

	// width select
	assign result = word_mode ? word_result : half_result;

endmodule

// File: logic/spu_result_pipe.sv
`timescale 1ns/100ps

module spu_result_pipe (
	input logic clk,
	input logic reset,
	input logic issue_we,
	input logic [0:spu_shift_pkg::reg_addr_w-1] issue_rt,
	input logic [0:spu_shift_pkg::data_w-1] result,
	input logic [0:spu_shift_pkg::reg_addr_w-1] ra_addr,
	input logic [0:spu_shift_pkg::reg_addr_w-1] rb_addr,
	input logic uses_rb,
	output logic hazard,
	output logic wb_we,
	output logic [0:spu_shift_pkg::reg_addr_w-1] wb_addr,
	output logic [0:spu_shift_pkg::data_w-1] wb_data
);

	localparam int last = spu_shift_pkg::wb_depth - 1;

	// stage 0 is the youngest
	logic [0:last] st_we;
	logic [0:spu_shift_pkg::reg_addr_w-1] st_addr [spu_shift_pkg::wb_depth];
	logic [0:spu_shift_pkg::data_w-1] st_data [spu_shift_pkg::wb_depth];

	// enables shift every cycle, bubbles enter while issue is stalled
	always_ff @(posedge clk) begin
		if (reset) begin
			st_we <= '0;
		end else begin
			st_we <= {issue_we, st_we[0:last-1]};
		end
	end

	always_ff @(posedge clk) begin
		st_addr[0] <= issue_rt;
		st_data[0] <= result;
		for (int s = 1; s < spu_shift_pkg::wb_depth; s++) begin
			st_addr[s] <= st_addr[s-1];
			st_data[s] <= st_data[s-1];
		end
	end

	// read-after-write against every pending write, the last stage too
	// since the file only takes its value at the next edge
	always_comb begin
		hazard = 1'b0;
		for (int s = 0; s < spu_shift_pkg::wb_depth; s++) begin
			if (st_we[s] && ((st_addr[s] == ra_addr) || (uses_rb && (st_addr[s] == rb_addr)))) begin
				hazard = 1'b1;
			end
		end
	end

	// oldest stage drives the file
	assign wb_we = st_we[last];
	assign wb_addr = st_addr[last];
	assign wb_data = st_data[last];

	// a real write must carry a known target and value out of the pipe
	property p_wb_known;
		@(posedge clk) disable iff (reset)
		!$isunknown(wb_we) && (!wb_we || !$isunknown({wb_addr, wb_data}));
	endproperty
	a_wb_known: assert property (p_wb_known)
		else $error("unknown write-back at r%0d", wb_addr);

endmodule

// File: logic/spu_shift_pipe_top.sv
`timescale 1ns/100ps

module spu_shift_pipe_top (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input spu_shift_pkg::instr_t in_instr,
	input logic in_squash,
	output logic in_ready,
	input logic ext_we,
	input logic [0:spu_shift_pkg::reg_addr_w-1] ext_addr,
	input logic [0:spu_shift_pkg::data_w-1] ext_data,
	output logic wb_we,
	output logic [0:spu_shift_pkg::reg_addr_w-1] wb_addr,
	output logic [0:spu_shift_pkg::data_w-1] wb_data
);

	// source addresses and operands
	logic [0:spu_shift_pkg::reg_addr_w-1] ra_addr;
	logic [0:spu_shift_pkg::reg_addr_w-1] rb_addr;
	logic [0:spu_shift_pkg::data_w-1] ra_data;
	logic [0:spu_shift_pkg::data_w-1] rb_data;

	// decoded controls from issue
	logic issue_we;
	logic [0:spu_shift_pkg::reg_addr_w-1] issue_rt;
	spu_shift_pkg::shift_kind_t kind;
	logic word_mode;
	logic use_imm;
	logic [0:spu_shift_pkg::imm_w-1] imm7;
	logic uses_rb;

	logic [0:spu_shift_pkg::data_w-1] result;
	logic hazard;

	spu_regfile u_regfile (
		.clk, .reset,
		.ra_addr, .rb_addr,
		.ra_data, .rb_data,
		.wb_we, .wb_addr, .wb_data,
		.ext_we, .ext_addr, .ext_data
	);

	spu_issue_ctrl u_issue_ctrl (
		.clk, .reset,
		.in_valid, .in_instr, .in_squash, .in_ready,
		.hazard,
		.ra_addr, .rb_addr,
		.issue_we, .issue_rt,
		.kind, .word_mode, .use_imm, .imm7, .uses_rb
	);

	spu_shift_rotate u_shift_rotate (
		.ra_data, .rb_data,
		.imm7, .use_imm,
		.kind, .word_mode,
		.result
	);

	spu_result_pipe u_result_pipe (
		.clk, .reset,
		.issue_we, .issue_rt, .result,
		.ra_addr, .rb_addr, .uses_rb,
		.hazard,
		.wb_we, .wb_addr, .wb_data
	);

endmodule

// File: test/spu_shift_model.svh
`ifndef spu_shift_model_svh
`define spu_shift_model_svh

// reference for one lane
// bit b of x has weight 2**b and the element is the low w bits
function automatic logic [31:0] shift_lane(input logic [31:0] x, input int w,
		input spu_shift_pkg::shift_kind_t kind, input int cnt);
	int c;
	logic [31:0] r;
	logic sign;
	r = '0;
	sign = x[w-1];
	case (kind)
		spu_shift_pkg::shift_left: begin
			c = cnt & (2 * w - 1);
			for (int b = 0; b < w; b++) begin
				if (b >= c)
					r[b] = x[b-c];
			end
		end
		spu_shift_pkg::rotate: begin
			c = cnt & (w - 1);
			for (int b = 0; b < w; b++) begin
				r[b] = x[(b - c + w) % w];
			end
		end
		default: begin
			// negated count then a right shift with zero or sign fill
			c = (0 - cnt) & (2 * w - 1);
			for (int b = 0; b < w; b++) begin
				if (b + c < w)
					r[b] = x[b+c];
				else if (kind == spu_shift_pkg::rotate_mask_alg)
					r[b] = sign;
			end
		end
	endcase
	return r;
endfunction

// returns 1 when op writes rt
// also gives class, element width and form
function automatic bit decode_op(input logic [0:spu_shift_pkg::op_w-1] op,
		output spu_shift_pkg::shift_kind_t kind, output int w, output bit imm);
	kind = spu_shift_pkg::shift_left;
	w = 32;
	imm = 0;
	case (op)
		spu_shift_pkg::op_shlh, spu_shift_pkg::op_shl,
		spu_shift_pkg::op_shli: kind = spu_shift_pkg::shift_left;
		spu_shift_pkg::op_roth, spu_shift_pkg::op_rot,
		spu_shift_pkg::op_rothi, spu_shift_pkg::op_roti: kind = spu_shift_pkg::rotate;
		spu_shift_pkg::op_rothm, spu_shift_pkg::op_rotm: kind = spu_shift_pkg::rotate_mask;
		spu_shift_pkg::op_rotmah, spu_shift_pkg::op_rotma,
		spu_shift_pkg::op_rotmahi, spu_shift_pkg::op_rotmai: kind = spu_shift_pkg::rotate_mask_alg;
		default: return 0;
	endcase
	if (op inside {spu_shift_pkg::op_shlh, spu_shift_pkg::op_roth, spu_shift_pkg::op_rothm,
			spu_shift_pkg::op_rotmah, spu_shift_pkg::op_rothi, spu_shift_pkg::op_rotmahi})
		w = 16;
	imm = op inside {spu_shift_pkg::op_shli, spu_shift_pkg::op_rothi, spu_shift_pkg::op_roti,
		spu_shift_pkg::op_rotmahi, spu_shift_pkg::op_rotmai};
	return 1;
endfunction

// full 128-bit result
// zero for an op that writes nothing
function automatic logic [0:127] expected_result(input spu_shift_pkg::instr_t instr,
		input logic [0:127] ra, input logic [0:127] rb);
	spu_shift_pkg::shift_kind_t kind;
	int w;
	bit imm;
	int cnt;
	logic [31:0] x;
	logic [31:0] cv;
	logic [31:0] r;
	logic [0:127] out;
	out = '0;
	if (!decode_op(instr.rr.op, kind, w, imm))
		return out;
	for (int l = 0; l < 128 / w; l++) begin
		x = '0;
		cv = '0;
		// bit 0 of a lane is its msb
		for (int b = 0; b < w; b++) begin
			x[w-1-b] = ra[l*w+b];
			cv[w-1-b] = rb[l*w+b];
		end
		cnt = imm ? int'($signed(instr.ri7.imm7)) : int'(cv);
		r = shift_lane(x, w, kind, cnt);
		for (int b = 0; b < w; b++) begin
			out[l*w+b] = r[w-1-b];
		end
	end
	return out;
endfunction

`endif

// File: test/spu_shift_pipe_tb.sv
`timescale 1ns/100ps

module spu_shift_pipe_tb;

	`include "spu_shift_model.svh"

	localparam int clk_period = 20;
	// accept edge to the edge where wb is sampled
	localparam int wb_latency = 5;
	localparam int n_reg_rep = 4;
	localparam int n_imm_rep = 6;
	localparam int n_dep_rep = 3;
	localparam int n_burst = 20;
	// dependent phase sends 2 + d per pair for d = 0..3
	// nop and squash phase sends 6
	localparam int n_instr = 8 * n_reg_rep + 5 * n_imm_rep + 14 * n_dep_rep + 6 + n_burst;
	localparam int watchdog_cycles = n_instr * 6 + 200;

	// register forms first and immediate forms after them
	localparam logic [0:10] all_ops [13] = '{
		spu_shift_pkg::op_shlh, spu_shift_pkg::op_shl, spu_shift_pkg::op_roth,
		spu_shift_pkg::op_rot, spu_shift_pkg::op_rothm, spu_shift_pkg::op_rotm,
		spu_shift_pkg::op_rotmah, spu_shift_pkg::op_rotma, spu_shift_pkg::op_shli,
		spu_shift_pkg::op_rothi, spu_shift_pkg::op_roti, spu_shift_pkg::op_rotmahi,
		spu_shift_pkg::op_rotmai
	};

	typedef struct packed {
		logic [0:6] addr;
		logic [0:127] data;
		int acc;
		bit exact;
	} wb_entry_t;

	logic clk;
	logic reset;
	logic in_valid;
	spu_shift_pkg::instr_t in_instr;
	logic in_squash;
	logic in_ready;
	logic ext_we;
	logic [0:6] ext_addr;
	logic [0:127] ext_data;
	logic wb_we;
	logic [0:6] wb_addr;
	logic [0:127] wb_data;

	// reference register file kept in program order
	logic [0:127] model_regs [128];
	wb_entry_t exp_q [$];
	wb_entry_t head;
	bit head_valid;
	bit burst;
	logic [31:0] rng;
	int cyc;
	int value_errors;
	int protocol_errors;
	int accepted;
	int checked;
	int stall_cycles;

	spu_shift_pipe_top DUT (
		.clk, .reset,
		.in_valid, .in_instr, .in_squash, .in_ready,
		.ext_we, .ext_addr, .ext_data,
		.wb_we, .wb_addr, .wb_data
	);

	always #(clk_period / 2) clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// next write the pipe owes the file
	task automatic load_head();
		head_valid = (exp_q.size() != 0);
		if (head_valid) begin
			head = exp_q[0];
		end
	endtask

	// retire the head once its write-back has been seen
	always @(posedge clk) begin
		if (!reset && wb_we) begin
			checked++;
			if (exp_q.size() != 0) begin
				void'(exp_q.pop_front());
			end
			load_head();
		end
		if (!reset && in_valid && !in_ready) begin
			stall_cycles++;
		end
	end

	// in_ready and wb_we stay low right after reset
	a_reset_quiet: assert property (@(posedge clk) $fell(reset) |-> !wb_we && !in_ready)
		else begin
			$display("Fail %0t in_ready got %b expected 0 wb_we got %b expected 0", $time,
				$sampled(in_ready), $sampled(wb_we));
			protocol_errors++;
		end

	// a squash, nop or unknown opcode must leave no pulse behind
	a_wb_expected: assert property (@(posedge clk) disable iff (reset) wb_we |-> head_valid)
		else begin
			$display("Fail %0t wb_we got 1 expected 0 for a write to r%0d", $time,
				$sampled(wb_addr));
			protocol_errors++;
		end

	a_wb_addr: assert property (@(posedge clk) disable iff (reset)
		wb_we && head_valid |-> wb_addr == head.addr)
		else begin
			$display("Fail %0t wb_addr got %0d expected %0d", $time, $sampled(wb_addr),
				$sampled(head.addr));
			value_errors++;
		end

	a_wb_data: assert property (@(posedge clk) disable iff (reset)
		wb_we && head_valid |-> wb_data == head.data)
		else begin
			$display("Fail %0t wb_data got %h expected %h", $time, $sampled(wb_data),
				$sampled(head.data));
			value_errors++;
		end

	// stalled consumers may only come later than the fixed latency
	a_wb_latency: assert property (@(posedge clk) disable iff (reset)
		wb_we && head_valid |-> (cyc - head.acc == wb_latency)
			|| (!head.exact && (cyc - head.acc > wb_latency)))
		else begin
			$display("Fail %0t wb_we latency got %0d expected %0d", $time,
				$sampled(cyc) - $sampled(head.acc), wb_latency);
			value_errors++;
		end

	// independent back-to-back words go in every cycle
	a_burst_ready: assert property (@(posedge clk) disable iff (reset)
		burst && in_valid |-> in_ready)
		else begin
			$display("Fail %0t in_ready got %b expected 1", $time, $sampled(in_ready));
			protocol_errors++;
		end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// sources live in r0..r63 and results go to r64..r127
	function automatic logic [0:6] source_reg();
		return 7'(next_random() % 64);
	endfunction

	function automatic logic [0:6] dest_reg();
		return 7'(64 + next_random() % 64);
	endfunction

	function automatic spu_shift_pkg::instr_t make_instr(input logic [0:10] op,
			input logic [0:6] field, input logic [0:6] ra, input logic [0:6] rt);
		spu_shift_pkg::instr_t i;
		i = {op, field, ra, rt};
		return i;
	endfunction

	function automatic spu_shift_pkg::instr_t random_independent();
		int idx;
		logic [0:6] field;
		idx = next_random() % 13;
		field = (idx < 8) ? source_reg() : 7'(next_random());
		return make_instr(all_ops[idx], field, source_reg(), dest_reg());
	endfunction

	task automatic ext_write(input logic [0:6] addr, input logic [0:127] data);
		ext_we = 1'b1;
		ext_addr = addr;
		ext_data = data;
		model_regs[addr] = data;
		@(posedge clk);
		#2;
		ext_we = 1'b0;
	endtask

	// present one word and hold it until the DUT takes it
	task automatic send(input spu_shift_pkg::instr_t instr, input logic squash, input bit exact);
		spu_shift_pkg::shift_kind_t kind;
		int w;
		bit imm;
		wb_entry_t e;
		in_valid = 1'b1;
		in_instr = instr;
		in_squash = squash;
		@(negedge clk);
		while (!in_ready) begin
			@(negedge clk);
		end
		// taken on the coming edge so the model sources are already current
		if (!squash && decode_op(instr.rr.op, kind, w, imm)) begin
			e.addr = instr.rr.rt;
			e.data = expected_result(instr, model_regs[instr.rr.ra], model_regs[instr.rr.rb]);
			e.acc = cyc;
			e.exact = exact;
			model_regs[instr.rr.rt] = e.data;
			exp_q.push_back(e);
			load_head();
		end
		accepted++;
		@(posedge clk);
		#2;
		in_valid = 1'b0;
		in_squash = 1'b0;
	endtask

	// let every owed write retire and add a few quiet cycles
	task automatic drain();
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		repeat (8) @(posedge clk);
		#2;
	endtask

	initial begin
		#(watchdog_cycles * clk_period);
		$display("timeout after %0d cycles with %0d write-backs outstanding",
			watchdog_cycles, exp_q.size());
		$display("Test failed");
		$finish;
	end

	initial begin
		spu_shift_pkg::instr_t prod;
		logic [0:10] op;
		logic [0:6] imm;
		logic [0:6] other;
		int idx;
		clk = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_instr = '0;
		in_squash = 1'b0;
		ext_we = 1'b0;
		ext_addr = '0;
		ext_data = '0;
		rng = 32'h072000cc;
		cyc = 0;
		head = '0;
		head_valid = 1'b0;
		burst = 1'b0;
		for (int i = 0; i < 128; i++) begin
			model_regs[i] = '0;
		end
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;

		for (int i = 0; i < 128; i++) begin
			ext_write(7'(i), {next_random(), next_random(), next_random(), next_random()});
		end

		// register forms with counts from random rb lanes
		for (int o = 0; o < 8; o++) begin
			for (int k = 0; k < n_reg_rep; k++) begin
				send(make_instr(all_ops[o], source_reg(), source_reg(), dest_reg()), 1'b0, 1'b1);
			end
		end
		drain();

		// immediate forms with every other one negative
		for (int o = 8; o < 13; o++) begin
			for (int k = 0; k < n_imm_rep; k++) begin
				imm = 7'(next_random());
				if (k % 2 == 1) begin
					imm[0] = 1'b1;
				end
				send(make_instr(all_ops[o], imm, source_reg(), dest_reg()), 1'b0, 1'b1);
			end
		end
		drain();

		// consumer d words behind its producer
		for (int d = 0; d < 4; d++) begin
			for (int k = 0; k < n_dep_rep; k++) begin
				prod = random_independent();
				send(prod, 1'b0, 1'b1);
				for (int f = 0; f < d; f++) begin
					send(random_independent(), 1'b0, 1'b1);
				end
				idx = next_random() % 13;
				op = all_ops[idx];
				other = (idx < 8) ? source_reg() : 7'(next_random());
				if (idx < 8 && next_random() % 2 == 1) begin
					send(make_instr(op, prod.rr.rt, other, dest_reg()), 1'b0, 1'b0);
				end else begin
					send(make_instr(op, other, prod.rr.rt, dest_reg()), 1'b0, 1'b0);
				end
			end
		end
		drain();

		// a squashed write, a nop and an unknown opcode one at a time
		for (int k = 0; k < 2; k++) begin
			send(make_instr(spu_shift_pkg::op_shl, source_reg(), source_reg(), source_reg()),
				1'b1, 1'b1);
			drain();
			send(make_instr(spu_shift_pkg::op_nop, source_reg(), source_reg(), source_reg()),
				1'b0, 1'b1);
			drain();
			send(make_instr(11'h7ff, source_reg(), source_reg(), source_reg()), 1'b0, 1'b1);
			drain();
		end

		burst = 1'b1;
		for (int k = 0; k < n_burst; k++) begin
			send(random_independent(), 1'b0, 1'b1);
		end
		burst = 1'b0;
		drain();

		// whole file against the model
		for (int i = 0; i < 128; i++) begin
			assert (DUT.u_regfile.regs[i] === model_regs[i])
				else begin
					$display("Fail %0t regs[%0d] got %h expected %h", $time, i,
						DUT.u_regfile.regs[i], model_regs[i]);
					value_errors++;
				end
		end
		assert (stall_cycles > 0)
			else begin
				$display("dependent instructions never held in_ready low");
				protocol_errors++;
			end

		$display("errors: %0d value, %0d protocol; %0d accepted, %0d write-backs checked",
			value_errors, protocol_errors, accepted, checked);
		if (value_errors + protocol_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+test
logic/spu_shift_pkg.sv
logic/spu_regfile.sv
logic/spu_issue_ctrl.sv
logic/spu_shift_rotate.sv
logic/spu_result_pipe.sv
logic/spu_shift_pipe_top.sv
test/spu_shift_pipe_tb.sv
